// ==== build.f ====
hw/ctrl_pkg.sv
hw/ctrl_fsm.sv
hw/hazard_unit.sv
hw/fwd_unit.sv
hw/core_ctrl.sv
sim/tb_core_ctrl.sv

// ==== Makefile ====
# Verilator simulation of the core controller

BUILD_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_core_ctrl \
		--Mdir $(BUILD_DIR) -f build.f

run: compile
	./$(BUILD_DIR)/Vtb_core_ctrl > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "TEST FAILED" sim.log; then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) sim.log

// ==== sim/tb_core_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core_ctrl
  import ctrl_pkg::*;
();

  // random phase length, the directed phases add about 60 cycles
  localparam int RAND_CYCLES = 200;
  // generous margin over the whole sequence
  localparam int MAX_CYCLES  = 8 * (RAND_CYCLES + 50);

  logic clk = 1'b0;
  logic rst_n;
  logic fetch_enable_i, instr_valid_i, illegal_insn_i, mret_insn_i, pipe_flush_i;
  logic branch_taken_ex_i, int_req_i, ext_req_i, id_ready_i, ex_valid_i;
  logic data_req_ex_i, regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic csr_busy_i, csr_access_id_i, data_misaligned_i, mult_multicycle_i;
  logic [NUM_OPS-1:0] rd_ex_match_i, rd_wb_match_i, rd_alu_match_i;
  jump_e jump_in_dec_i;
  logic ctrl_busy_o, is_decoding_o, instr_req_o, pc_set_o;
  logic exc_ack_o, irq_ack_o, exc_save_if_o, exc_save_id_o, exc_restore_mret_o;
  logic halt_if_o, halt_id_o, load_stall_o, jr_stall_o, csr_stall_o, deassert_we_o;
  pc_mux_e pc_mux_o;
  fw_sel_e operand_a_sel_o, operand_b_sel_o, operand_c_sel_o;

  // phase flags, driven together with the stimulus
  logic booted, rand_phase, jal_phase, jal_first, jalr_phase, jalr_first;
  logic mret_phase, mret_first, exc_wait, exc_take, sleep_chk, wake_chk;

  int          err_count   = 0;
  int          cycle_count = 0;
  logic [31:0] rnd_state;

  always #4 clk = ~clk;

  core_ctrl u_core_ctrl (.*);

  //////////////////////////////////////////////////////////////////////
  // reference models
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // per operand: regfile, then WB, then EX on top; overrides last
  function automatic logic [5:0] fwd_model(input logic alu_we, input logic wb_we,
      input logic [NUM_OPS-1:0] alu_m, input logic [NUM_OPS-1:0] wb_m,
      input logic mis, input logic mult);
    logic [FW_SEL_W-1:0] s [NUM_OPS];
    for (int i = 0; i < NUM_OPS; i++) begin
      s[i] = SEL_REGFILE;
      if (wb_we && wb_m[i]) begin
        s[i] = SEL_FW_WB;
      end
      if (alu_we && alu_m[i]) begin
        s[i] = SEL_FW_EX;
      end
    end
    if (mis) begin
      s[0] = SEL_FW_EX;
      s[1] = SEL_REGFILE;
    end else if (mult) begin
      s[2] = SEL_FW_EX;
    end
    return {s[0], s[1], s[2]};
  endfunction

  // {load, jr, csr}
  function automatic logic [2:0] stall_model(input logic ld_req, input logic we_ex,
      input logic we_wb, input logic we_alu, input logic [NUM_OPS-1:0] ex_m,
      input logic [NUM_OPS-1:0] wb_m, input logic [NUM_OPS-1:0] alu_m,
      input jump_e jmp, input logic busy, input logic acc);
    logic ld;
    logic jr;
    logic csr;
    ld  = ld_req && we_ex && (ex_m != '0);
    jr  = (jmp == BRANCH_JALR) &&
          ((we_ex && ex_m[0]) || (we_wb && wb_m[0]) || (we_alu && alu_m[0]));
    csr = busy && acc;
    return {ld, jr, csr};
  endfunction

  logic [5:0] sel_act, sel_exp;
  logic [2:0] hz_exp;
  logic [3:0] stall_act, stall_exp, redirect;
  logic [4:0] quiet;

  assign sel_act   = {operand_a_sel_o, operand_b_sel_o, operand_c_sel_o};
  assign sel_exp   = fwd_model(regfile_alu_we_fw_i, regfile_we_wb_i, rd_alu_match_i,
                               rd_wb_match_i, data_misaligned_i, mult_multicycle_i);
  assign hz_exp    = stall_model(data_req_ex_i, regfile_we_ex_i, regfile_we_wb_i,
                                 regfile_alu_we_fw_i, rd_ex_match_i, rd_wb_match_i,
                                 rd_alu_match_i, jump_in_dec_i, csr_busy_i, csr_access_id_i);
  assign stall_exp = {hz_exp, (|hz_exp) | illegal_insn_i | ~is_decoding_o};
  assign stall_act = {load_stall_o, jr_stall_o, csr_stall_o, deassert_we_o};
  assign redirect  = {pc_set_o, pc_mux_o};
  assign quiet     = {instr_req_o, ctrl_busy_o, pc_set_o, halt_if_o, halt_id_o};

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
      input logic [31:0] act_v);
    err_count++;
    $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_reset: assert property (@(posedge clk) !booted |-> quiet == 5'd0)
    else report_mismatch("quiet", 32'd0, 32'($sampled(quiet)));
  a_boot: assert property (@(posedge clk)
      $past(fetch_enable_i) && !$past(fetch_enable_i, 2) |-> redirect == {1'b1, PC_BOOT})
    else report_mismatch("pc_set_o/pc_mux_o", 32'({1'b1, PC_BOOT}), 32'($sampled(redirect)));
  a_fwd: assert property (@(posedge clk) sel_act == sel_exp)
    else report_mismatch("operand_sel", 32'($sampled(sel_exp)), 32'($sampled(sel_act)));
  a_stall: assert property (@(posedge clk) stall_act == stall_exp)
    else report_mismatch("stalls/deassert_we_o", 32'($sampled(stall_exp)),
                         32'($sampled(stall_act)));
  // taken branch also drops decoding in the same cycle
  a_branch: assert property (@(posedge clk) rand_phase && branch_taken_ex_i |->
      {redirect, is_decoding_o} == {1'b1, PC_BRANCH, 1'b0})
    else report_mismatch("pc_set_o/pc_mux_o/is_decoding_o", 32'({1'b1, PC_BRANCH, 1'b0}),
                         32'($sampled({redirect, is_decoding_o})));
  a_jal: assert property (@(posedge clk) jal_phase |-> redirect == {jal_first, PC_JUMP})
    else report_mismatch("pc_set_o/pc_mux_o", 32'($sampled({jal_first, PC_JUMP})),
                         32'($sampled(redirect)));
  a_jalr: assert property (@(posedge clk) jalr_phase |-> redirect == {jalr_first, PC_JUMP})
    else report_mismatch("pc_set_o/pc_mux_o", 32'($sampled({jalr_first, PC_JUMP})),
                         32'($sampled(redirect)));
  a_mret: assert property (@(posedge clk) mret_phase |->
      {redirect, exc_restore_mret_o} == {mret_first, PC_ERET, 1'b1})
    else report_mismatch("pc_set_o/pc_mux_o/exc_restore_mret_o",
                         32'($sampled({mret_first, PC_ERET, 1'b1})),
                         32'($sampled({redirect, exc_restore_mret_o})));
  a_exc_halt: assert property (@(posedge clk) exc_wait |-> {halt_if_o, halt_id_o} == 2'b11)
    else report_mismatch("halt_if_o/halt_id_o", 32'd3, 32'($sampled({halt_if_o, halt_id_o})));
  a_exc_take: assert property (@(posedge clk) exc_take |->
      {redirect, exc_ack_o, exc_save_id_o} == {1'b1, PC_EXCEPTION, 2'b11})
    else report_mismatch("pc_set_o/pc_mux_o/exc_ack_o/exc_save_id_o",
                         32'({1'b1, PC_EXCEPTION, 2'b11}),
                         32'($sampled({redirect, exc_ack_o, exc_save_id_o})));
  a_sleep: assert property (@(posedge clk) sleep_chk |-> !ctrl_busy_o)
    else report_mismatch("ctrl_busy_o", 32'd0, 32'($sampled(ctrl_busy_o)));
  a_wake: assert property (@(posedge clk) wake_chk |->
      {redirect, exc_ack_o, irq_ack_o, exc_save_if_o} == {1'b1, PC_EXCEPTION, 3'b111})
    else report_mismatch("pc_set_o/pc_mux_o/exc_ack_o/irq_ack_o/exc_save_if_o",
                         32'({1'b1, PC_EXCEPTION, 3'b111}),
                         32'($sampled({redirect, exc_ack_o, irq_ack_o, exc_save_if_o})));

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_random();
    logic [31:0] r0;
    logic [31:0] r1;
    rnd_state = lcg_next(rnd_state);
    r0 = rnd_state;
    rnd_state = lcg_next(rnd_state);
    r1 = rnd_state;
    instr_valid_i       <= r0[31] | r0[30];
    branch_taken_ex_i   <= r0[29] & r0[28];
    jump_in_dec_i       <= jump_e'(r0[27:26]);
    id_ready_i          <= r0[25];
    illegal_insn_i      <= r0[24] & r0[23];
    data_req_ex_i       <= r0[22];
    regfile_we_ex_i     <= r0[21];
    regfile_we_wb_i     <= r0[20];
    regfile_alu_we_fw_i <= r0[19];
    csr_busy_i          <= r0[18];
    csr_access_id_i     <= r0[17];
    rd_ex_match_i       <= r1[31:29];
    rd_wb_match_i       <= r1[28:26];
    rd_alu_match_i      <= r1[25:23];
    data_misaligned_i   <= r1[22] & r1[21];
    mult_multicycle_i   <= r1[20];
  endtask

  // valid instruction, no hazards, id_ready high so jump_done clears
  task automatic drive_quiet_decode();
    {branch_taken_ex_i, illegal_insn_i, data_req_ex_i, csr_busy_i, csr_access_id_i} <= '0;
    {regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i} <= '0;
    {data_misaligned_i, mult_multicycle_i, mret_insn_i} <= '0;
    {rd_ex_match_i, rd_wb_match_i, rd_alu_match_i} <= '0;
    jump_in_dec_i <= BRANCH_NONE;
    instr_valid_i <= 1'b1;
    id_ready_i    <= 1'b1;
  endtask

  // first redirect after enable is the boot pc
  task automatic wait_redirect();
    do @(posedge clk); while (!pc_set_o);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: sequence still running after %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    rnd_state = 32'h9f7f_5ed8;
    rst_n <= 1'b0;
    fetch_enable_i <= 1'b0;
    drive_quiet_decode();
    {instr_valid_i, id_ready_i, pipe_flush_i, int_req_i, ext_req_i, ex_valid_i} <= '0;
    {booted, rand_phase, jal_phase, jal_first, jalr_phase, jalr_first} <= '0;
    {mret_phase, mret_first, exc_wait, exc_take, sleep_chk, wake_chk} <= '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);

    // boot, then FIRST_FETCH waits for ID
    fetch_enable_i <= 1'b1;
    booted         <= 1'b1;
    wait_redirect();
    id_ready_i <= 1'b1;
    @(posedge clk);

    // random hazards and branches while sitting in DECODE
    rand_phase <= 1'b1;
    repeat (RAND_CYCLES) begin
      drive_random();
      @(posedge clk);
    end
    rand_phase <= 1'b0;
    drive_quiet_decode();
    @(posedge clk);

    // jal held in ID, one redirect only
    jump_in_dec_i <= BRANCH_JAL;
    id_ready_i    <= 1'b0;
    {jal_phase, jal_first} <= 2'b11;
    @(posedge clk);
    jal_first <= 1'b0;
    repeat (5) @(posedge clk);
    jal_phase <= 1'b0;
    drive_quiet_decode();
    @(posedge clk);

    // jalr blocked by a pending EX write to operand A
    jump_in_dec_i   <= BRANCH_JALR;
    id_ready_i      <= 1'b0;
    regfile_we_ex_i <= 1'b1;
    rd_ex_match_i   <= 3'b001;
    jalr_phase      <= 1'b1;
    repeat (4) @(posedge clk);
    rd_ex_match_i <= '0;
    jalr_first    <= 1'b1;
    @(posedge clk);
    jalr_first <= 1'b0;
    repeat (3) @(posedge clk);
    jalr_phase <= 1'b0;
    drive_quiet_decode();
    @(posedge clk);

    // mret with the core enabled stays in DECODE
    mret_insn_i <= 1'b1;
    id_ready_i  <= 1'b0;
    {mret_phase, mret_first} <= 2'b11;
    @(posedge clk);
    mret_first <= 1'b0;
    repeat (3) @(posedge clk);
    mret_phase <= 1'b0;
    drive_quiet_decode();
    @(posedge clk);

    // exception: halt through FLUSH_EX, take it in FLUSH_WB
    int_req_i <= 1'b1;
    exc_wait  <= 1'b1;
    repeat (3) @(posedge clk);
    ex_valid_i <= 1'b1;
    @(posedge clk);
    ex_valid_i <= 1'b0;
    exc_wait   <= 1'b0;
    exc_take   <= 1'b1;
    @(posedge clk);
    int_req_i <= 1'b0;
    exc_take  <= 1'b0;
    @(posedge clk);

    // wfi with the core disabled ends in SLEEP
    pipe_flush_i   <= 1'b1;
    fetch_enable_i <= 1'b0;
    @(posedge clk);
    pipe_flush_i  <= 1'b0;
    instr_valid_i <= 1'b0;
    ex_valid_i    <= 1'b1;
    @(posedge clk);
    ex_valid_i <= 1'b0;
    @(posedge clk);
    sleep_chk <= 1'b1;
    repeat (4) @(posedge clk);

    // interrupt wakes the core and is taken in FIRST_FETCH
    sleep_chk <= 1'b0;
    ext_req_i <= 1'b1;
    @(posedge clk);
    wake_chk <= 1'b1;
    @(posedge clk);
    wake_chk  <= 1'b0;
    ext_req_i <= 1'b0;
    repeat (3) @(posedge clk);

    $display("run complete after %0d cycles, %0d errors", cycle_count, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/core_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_ctrl
  import ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_enable_i,

  // decoder
  input  logic               instr_valid_i,
  input  logic               illegal_insn_i,
  input  logic               mret_insn_i,
  input  logic               pipe_flush_i,
  input  jump_e              jump_in_dec_i,
  input  logic               branch_taken_ex_i,

  // exception controller
  input  logic               int_req_i,
  input  logic               ext_req_i,

  // pipeline progress
  input  logic               id_ready_i,
  input  logic               ex_valid_i,

  // register write ports and operand matches
  input  logic               data_req_ex_i,
  input  logic               regfile_we_ex_i,
  input  logic               regfile_we_wb_i,
  input  logic               regfile_alu_we_fw_i,
  input  logic [NUM_OPS-1:0] rd_ex_match_i,
  input  logic [NUM_OPS-1:0] rd_wb_match_i,
  input  logic [NUM_OPS-1:0] rd_alu_match_i,

  input  logic               csr_busy_i,
  input  logic               csr_access_id_i,
  input  logic               data_misaligned_i,
  input  logic               mult_multicycle_i,

  // fetch and status
  output logic               ctrl_busy_o,
  output logic               is_decoding_o,
  output logic               instr_req_o,
  output logic               pc_set_o,
  output pc_mux_e            pc_mux_o,

  // exception handshake
  output logic               exc_ack_o,
  output logic               irq_ack_o,
  output logic               exc_save_if_o,
  output logic               exc_save_id_o,
  output logic               exc_restore_mret_o,

  output logic               halt_if_o,
  output logic               halt_id_o,

  // stalls
  output logic               load_stall_o,
  output logic               jr_stall_o,
  output logic               csr_stall_o,
  output logic               deassert_we_o,

  // operand muxes in ID
  output fw_sel_e            operand_a_sel_o,
  output fw_sel_e            operand_b_sel_o,
  output fw_sel_e            operand_c_sel_o
);

  // fsm to hazard unit and back
  logic is_decoding;
  logic jr_stall;

  assign is_decoding_o = is_decoding;
  assign jr_stall_o    = jr_stall;

  //////////////////////////////////////////////////////////////////////
  // control fsm
  //////////////////////////////////////////////////////////////////////

  ctrl_fsm u_ctrl_fsm (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable_i),
    .instr_valid_i      (instr_valid_i),
    .branch_taken_ex_i  (branch_taken_ex_i),
    .jump_in_dec_i      (jump_in_dec_i),
    .mret_insn_i        (mret_insn_i),
    .pipe_flush_i       (pipe_flush_i),
    .int_req_i          (int_req_i),
    .ext_req_i          (ext_req_i),
    .id_ready_i         (id_ready_i),
    .ex_valid_i         (ex_valid_i),
    .jr_stall_i         (jr_stall),
    .ctrl_busy_o        (ctrl_busy_o),
    .is_decoding_o      (is_decoding),
    .instr_req_o        (instr_req_o),
    .pc_set_o           (pc_set_o),
    .pc_mux_o           (pc_mux_o),
    .exc_ack_o          (exc_ack_o),
    .irq_ack_o          (irq_ack_o),
    .exc_save_if_o      (exc_save_if_o),
    .exc_save_id_o      (exc_save_id_o),
    .exc_restore_mret_o (exc_restore_mret_o),
    .halt_if_o          (halt_if_o),
    .halt_id_o          (halt_id_o)
  );

  //////////////////////////////////////////////////////////////////////
  // hazards and forwarding
  //////////////////////////////////////////////////////////////////////

  hazard_unit u_hazard_unit (
    .is_decoding_i       (is_decoding),
    .illegal_insn_i      (illegal_insn_i),
    .data_req_ex_i       (data_req_ex_i),
    .regfile_we_ex_i     (regfile_we_ex_i),
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .rd_ex_match_i       (rd_ex_match_i),
    .rd_wb_match_i       (rd_wb_match_i),
    .rd_alu_match_i      (rd_alu_match_i),
    .jump_in_dec_i       (jump_in_dec_i),
    .csr_busy_i          (csr_busy_i),
    .csr_access_id_i     (csr_access_id_i),
    .load_stall_o        (load_stall_o),
    .jr_stall_o          (jr_stall),
    .csr_stall_o         (csr_stall_o),
    .deassert_we_o       (deassert_we_o)
  );

  // selects only depend on top-level inputs
  fwd_unit u_fwd_unit (
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .rd_wb_match_i       (rd_wb_match_i),
    .rd_alu_match_i      (rd_alu_match_i),
    .data_misaligned_i   (data_misaligned_i),
    .mult_multicycle_i   (mult_multicycle_i),
    .operand_a_sel_o     (operand_a_sel_o),
    .operand_b_sel_o     (operand_b_sel_o),
    .operand_c_sel_o     (operand_c_sel_o)
  );

endmodule

`default_nettype wire

// ==== hw/fwd_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fwd_unit
  import ctrl_pkg::*;
(
  // write ports ahead of ID
  input  logic               regfile_we_wb_i,
  input  logic               regfile_alu_we_fw_i,
  input  logic [NUM_OPS-1:0] rd_wb_match_i,
  input  logic [NUM_OPS-1:0] rd_alu_match_i,

  // lsu and multiplier overrides
  input  logic               data_misaligned_i,
  input  logic               mult_multicycle_i,

  output fw_sel_e            operand_a_sel_o,
  output fw_sel_e            operand_b_sel_o,
  output fw_sel_e            operand_c_sel_o
);

  // index 0 is A, 1 is B, 2 is C
  fw_sel_e sel [NUM_OPS];

  always_comb begin
    for (int i = 0; i < NUM_OPS; i++) begin
      // nearest producer wins
      if (regfile_alu_we_fw_i && rd_alu_match_i[i]) begin
        sel[i] = SEL_FW_EX;
      end else if (regfile_we_wb_i && rd_wb_match_i[i]) begin
        sel[i] = SEL_FW_WB;
      end else begin
        sel[i] = SEL_REGFILE;
      end
    end

    // second half of a misaligned access
    // A takes the address from EX, B is the plain register
    if (data_misaligned_i) begin
      sel[0] = SEL_FW_EX;
      sel[1] = SEL_REGFILE;
    end else if (mult_multicycle_i) begin
      // multiplier keeps its partial result on C
      sel[2] = SEL_FW_EX;
    end
  end

  assign operand_a_sel_o = sel[0];
  assign operand_b_sel_o = sel[1];
  assign operand_c_sel_o = sel[2];

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
  import ctrl_pkg::*;
(
  // decode status
  input  logic               is_decoding_i,
  input  logic               illegal_insn_i,

  // load in EX
  input  logic               data_req_ex_i,

  // write ports that may target an ID operand
  input  logic               regfile_we_ex_i,
  input  logic               regfile_we_wb_i,
  input  logic               regfile_alu_we_fw_i,
  input  logic [NUM_OPS-1:0] rd_ex_match_i,
  input  logic [NUM_OPS-1:0] rd_wb_match_i,
  input  logic [NUM_OPS-1:0] rd_alu_match_i,

  input  jump_e              jump_in_dec_i,

  // csr file state
  input  logic               csr_busy_i,
  input  logic               csr_access_id_i,

  output logic               load_stall_o,
  output logic               jr_stall_o,
  output logic               csr_stall_o,
  output logic               deassert_we_o
);

  // per write port, does it hit operand A
  logic wb_hits_a;
  logic ex_hits_a;
  logic alu_hits_a;

  assign wb_hits_a  = regfile_we_wb_i     & rd_wb_match_i[0];
  assign ex_hits_a  = regfile_we_ex_i     & rd_ex_match_i[0];
  assign alu_hits_a = regfile_alu_we_fw_i & rd_alu_match_i[0];

  // load data is not ready before WB, so any consumer waits
  assign load_stall_o = data_req_ex_i & regfile_we_ex_i & (|rd_ex_match_i);

  // jalr target is computed in ID, no forwarding onto the pc path
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & (wb_hits_a | ex_hits_a | alu_hits_a);

  // coarse check, any csr access waits for a busy csr file
  assign csr_stall_o = csr_busy_i & csr_access_id_i;

  // the instruction in ID must not write back
  assign deassert_we_o = load_stall_o | jr_stall_o | csr_stall_o |
                         illegal_insn_i | ~is_decoding_i;

endmodule

`default_nettype wire

// ==== hw/ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm
  import ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  // core enable
  input  logic    fetch_enable_i,

  // instruction in ID and branch result from EX
  input  logic    instr_valid_i,
  input  logic    branch_taken_ex_i,
  input  jump_e   jump_in_dec_i,
  input  logic    mret_insn_i,
  input  logic    pipe_flush_i,

  // exception controller requests
  input  logic    int_req_i,
  input  logic    ext_req_i,

  // pipeline progress
  input  logic    id_ready_i,
  input  logic    ex_valid_i,

  // jump target register still in flight
  input  logic    jr_stall_i,

  output logic    ctrl_busy_o,
  output logic    is_decoding_o,
  output logic    instr_req_o,
  output logic    pc_set_o,
  output pc_mux_e pc_mux_o,

  output logic    exc_ack_o,
  output logic    irq_ack_o,
  output logic    exc_save_if_o,
  output logic    exc_save_id_o,
  output logic    exc_restore_mret_o,

  output logic    halt_if_o,
  output logic    halt_id_o
);

  // state encoding is private to this block
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // one redirect per jump, held until ID accepts the next instruction
  logic jump_done_q;
  logic jump_done_d;

  logic exc_req;
  logic is_jump;

  // any request that needs the trap vector
  assign exc_req = int_req_i | ext_req_i;
  // only unconditional jumps redirect from ID
  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // defaults for a running core
    state_d            = state_q;
    jump_done_d        = jump_done_q;
    instr_req_o        = 1'b1;
    ctrl_busy_o        = 1'b1;
    is_decoding_o      = 1'b0;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_ack_o          = 1'b0;
    irq_ack_o          = 1'b0;
    exc_save_if_o      = 1'b0;
    exc_save_id_o      = 1'b0;
    exc_restore_mret_o = 1'b0;
    halt_if_o          = 1'b0;
    halt_id_o          = 1'b0;

    case (state_q)
      // idle until the core is enabled
      RESET: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into the fetch stage
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // pipeline is empty, wait for enable or a request
      SLEEP: begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // a request that woke us is taken right away
        // pipeline was flushed before sleep, so the IF pc is the one to save
        if (exc_req) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          irq_ack_o     = ext_req_i;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE: begin
        // the ID instruction is dropped when EX takes a branch
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          // external interrupt beats everything decoded in ID
          if (ext_req_i) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end else if (is_jump) begin
            pc_mux_o = PC_JUMP;
            // jalr waits for its base register
            if (!jr_stall_i && !jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end else if (mret_insn_i) begin
            pc_mux_o           = PC_ERET;
            exc_restore_mret_o = 1'b1;
            if (!jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
            // return into sleep when the core was disabled
            if (!fetch_enable_i) begin
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
              state_d   = FLUSH_EX;
            end
          end else if (int_req_i) begin
            // ecall, illegal and friends
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end else if (pipe_flush_i) begin
            // wfi, drain and maybe sleep
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // taken branch in EX wins the pc select
        if (branch_taken_ex_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_BRANCH;
          is_decoding_o = 1'b0;
        end
      end

      // bubble into EX until the stage drains
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      // one cycle, WB is empty afterwards
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          state_d = DECODE;
          if (int_req_i) begin
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end else if (ext_req_i) begin
            pc_set_o      = 1'b1;
            pc_mux_o      = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            irq_ack_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end else begin
            // nothing to take, let fetch resume
            halt_if_o = 1'b0;
          end
        end else begin
          state_d = SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // ID took a new instruction, so the next jump may redirect again
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // pc source select toward the fetch stage
  localparam int PC_MUX_W = 3;
  // operand source select toward the ID operand muxes
  localparam int FW_SEL_W = 2;
  // control transfer kind coming out of the decoder
  localparam int JUMP_W   = 2;
  // register operands checked for hazards, bit 0 is A, 1 is B, 2 is C
  localparam int NUM_OPS  = 3;

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // value 1 is left unused in the fetch stage mux
  typedef enum logic [PC_MUX_W-1:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd2,
    PC_BRANCH    = 3'd3,
    PC_EXCEPTION = 3'd4,
    PC_ERET      = 3'd5
  } pc_mux_e;

  // where an ID-stage operand is taken from
  typedef enum logic [FW_SEL_W-1:0] {
    SEL_REGFILE = 2'd0,
    SEL_FW_EX   = 2'd1,
    SEL_FW_WB   = 2'd2
  } fw_sel_e;

  // jal and jalr resolve in ID, cond branches resolve in EX
  typedef enum logic [JUMP_W-1:0] {
    BRANCH_NONE = 2'd0,
    BRANCH_JAL  = 2'd1,
    BRANCH_JALR = 2'd2,
    BRANCH_COND = 2'd3
  } jump_e;

endpackage

`default_nettype wire
